// ==== hw/bus_int_macros.svh ====
//--------------------------------------------------------------------
// Board control register map
// Bus widths, register indices and reset values
//--------------------------------------------------------------------
`ifndef BUS_INT_MACROS_SVH
`define BUS_INT_MACROS_SVH

// Bus widths
`define BUS_INT_DATA_W     32
`define BUS_INT_REG_AW     8

// Write register indices (APB byte address / 4)
`define SR_LEDS            8'd0
`define SR_SW_RST          8'd1
`define SR_CLOCK_CTRL      8'd2
`define SR_DEVICE_ID       8'd3
`define SR_REF_FREQ        8'd4
`define SR_SFPP_CTRL0      8'd8
`define SR_SFPP_CTRL1      8'd9
`define SR_FP_GPIO_SRC     8'd72

// Readback indices
`define RB_COUNTER         8'd0
`define RB_CLK_STATUS      8'd3
`define RB_COMPAT_NUM      8'd6
`define RB_SFPP_STATUS0    8'd8
`define RB_SFPP_STATUS1    8'd9
`define RB_FP_GPIO_SRC     8'd13
`define RB_DEVICE_ID       8'd14

// Compatibility number
`define COMPAT_MAJOR       16'h0027
`define COMPAT_MINOR       16'h0000

// Reset values, bit 6 of clock control picks the GPSDO
`define CLOCK_CTRL_RESET   8'h40
`define REF_FREQ_RESET     32'd10_000_000

// SFP+ status
`define PHY_STATUS_W       16
`define SYNC_STAGES        2

`endif

// ==== hw/bus_int_pkg.sv ====
//--------------------------------------------------------------------
// Types shared by the board control block
//--------------------------------------------------------------------
`default_nettype none

`include "bus_int_macros.svh"

package bus_int_pkg;

   //--------------------------------------------------------------------
   // Internal register request from the APB bridge
   //--------------------------------------------------------------------
   typedef struct packed {
      logic                       wr_stb;
      logic                       rd_stb;
      logic [`BUS_INT_REG_AW-1:0] idx;
      logic [`BUS_INT_DATA_W-1:0] wdata;
   } reg_req_t;

   //--------------------------------------------------------------------
   // Board level control outputs
   //--------------------------------------------------------------------
   typedef struct packed {
      logic [1:0]  leds;
      // PHY, radio clock, radio PLL, IDELAYCTRL resets
      logic [3:0]  sw_rst;
      logic [7:0]  clock_control;
      logic [15:0] device_id;
      logic [31:0] ref_freq;
      logic [1:0]  sfpp0_rs;
      logic [1:0]  sfpp1_rs;
      // Two bits per front-panel pin
      logic [23:0] fp_gpio_src;
   } board_ctrl_t;

   //--------------------------------------------------------------------
   // SFP+ cage pins and status word
   //--------------------------------------------------------------------
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfp_pins_t;

   typedef struct packed {
      logic [`PHY_STATUS_W-1:0] phy_status;
      logic [9:0]               reserved;
      logic                     mod_abs_chgd;
      logic                     tx_fault_chgd;
      logic                     rx_los_chgd;
      logic                     mod_abs;
      logic                     tx_fault;
      logic                     rx_los;
   } sfp_status_t;

endpackage

`default_nettype wire

// ==== hw/apb_reg_bridge.sv ====
//--------------------------------------------------------------------
// APB slave for the board control registers
// Zero wait states, read word captured at the end of setup
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module apb_reg_bridge (
   input  wire                          clk,
   input  wire                          i_reset,
   // APB slave
   input  wire                          i_psel,
   input  wire                          i_penable,
   input  wire                          i_pwrite,
   input  wire [`BUS_INT_REG_AW+1:0]    i_paddr,
   input  wire [`BUS_INT_DATA_W-1:0]    i_pwdata,
   output logic [`BUS_INT_DATA_W-1:0]   o_prdata,
   output logic                         o_pready,
   output logic                         o_pslverr,
   // Readback return
   input  wire [`BUS_INT_DATA_W-1:0]    i_rd_data,
   input  wire                          i_rd_hit,
   // Internal request
   output bus_int_pkg::reg_req_t        o_req
);

   logic setup_phase;
   logic access_phase;

   assign setup_phase  = i_psel && !i_penable;
   assign access_phase = i_psel && i_penable;

   // Strobes fire once, in the access phase
   always_comb begin
      o_req.wr_stb = access_phase && i_pwrite;
      o_req.rd_stb = access_phase && !i_pwrite;
      o_req.idx    = i_paddr[`BUS_INT_REG_AW+1:2];
      o_req.wdata  = i_pwdata;
   end

   //--------------------------------------------------------------------
   // Response, registered at the setup-to-access edge
   //--------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_pready  <= 1'b0;
         o_pslverr <= 1'b0;
         o_prdata  <= '0;
      end else begin
         o_pready  <= setup_phase;
         // Only unmapped reads fail
         o_pslverr <= setup_phase && !i_pwrite && !i_rd_hit;
         if (setup_phase) begin
            o_prdata <= (!i_pwrite && i_rd_hit) ? i_rd_data : '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/board_ctrl_regs.sv ====
//--------------------------------------------------------------------
// Board control write registers
// Holds LED, reset, clock, ID, reference and SFP+ controls
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module board_ctrl_regs (
   input  wire                     clk,
   input  wire                     i_reset,
   input  wire bus_int_pkg::reg_req_t i_req,
   output bus_int_pkg::board_ctrl_t   o_board_ctrl,
   output logic                    o_ref_freq_changed
);

   logic ref_freq_wr;

   assign ref_freq_wr = i_req.wr_stb && (i_req.idx == `SR_REF_FREQ);

   //--------------------------------------------------------------------
   // Register bank
   //--------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_board_ctrl               <= '0;
         o_board_ctrl.clock_control <= `CLOCK_CTRL_RESET;
         // 10 MHz reference by default
         o_board_ctrl.ref_freq      <= `REF_FREQ_RESET;
      end else if (i_req.wr_stb) begin
         case (i_req.idx)
            `SR_LEDS: begin
               o_board_ctrl.leds <= i_req.wdata[1:0];
            end
            `SR_SW_RST: begin
               o_board_ctrl.sw_rst <= i_req.wdata[3:0];
            end
            `SR_CLOCK_CTRL: begin
               o_board_ctrl.clock_control <= i_req.wdata[7:0];
            end
            `SR_DEVICE_ID: begin
               o_board_ctrl.device_id <= i_req.wdata[15:0];
            end
            `SR_REF_FREQ: begin
               o_board_ctrl.ref_freq <= i_req.wdata[31:0];
            end
            // Rate select, one drive enable per RS pin
            `SR_SFPP_CTRL0: begin
               o_board_ctrl.sfpp0_rs <= i_req.wdata[1:0];
            end
            `SR_SFPP_CTRL1: begin
               o_board_ctrl.sfpp1_rs <= i_req.wdata[1:0];
            end
            `SR_FP_GPIO_SRC: begin
               o_board_ctrl.fp_gpio_src <= i_req.wdata[23:0];
            end
            default: begin
               // Unmapped index, nothing to store
            end
         endcase
      end
   end

   //--------------------------------------------------------------------
   // Reference frequency change pulse
   //--------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= ref_freq_wr;
      end
   end

endmodule

`default_nettype wire

// ==== hw/sfp_status_monitor.sv ====
//--------------------------------------------------------------------
// SFP+ cage status monitor
// Synchronizes pins and PHY status, latches pin changes
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module sfp_status_monitor #(
   parameter int PHY_W = `PHY_STATUS_W
) (
   input  wire                        clk,
   input  wire                        i_reset,
   input  wire bus_int_pkg::sfp_pins_t i_pins,
   input  wire [PHY_W-1:0]            i_phy_status,
   input  wire                        i_clear,
   output bus_int_pkg::sfp_status_t   o_status
);

   import bus_int_pkg::*;

   sfp_pins_t        pins_sync [`SYNC_STAGES];
   logic [PHY_W-1:0] phy_sync  [`SYNC_STAGES];
   sfp_pins_t        pins_cur;
   sfp_pins_t        pins_prev;
   logic [2:0]       pin_diff;
   logic [2:0]       chgd_q;

   // All inputs are asynchronous to clk
   always_ff @(posedge clk) begin
      pins_sync[0] <= i_pins;
      phy_sync[0]  <= i_phy_status;
      for (int i = 1; i < `SYNC_STAGES; i++) begin
         pins_sync[i] <= pins_sync[i-1];
         phy_sync[i]  <= phy_sync[i-1];
      end
      pins_prev <= pins_cur;
   end

   assign pins_cur = pins_sync[`SYNC_STAGES-1];
   assign pin_diff = pins_cur ^ pins_prev;

   // Sticky change flags, a new change wins over a clear
   always_ff @(posedge clk) begin
      if (i_reset) begin
         chgd_q <= '0;
      end else if (i_clear) begin
         chgd_q <= pin_diff;
      end else begin
         chgd_q <= chgd_q | pin_diff;
      end
   end

   always_comb begin
      o_status            = '0;
      o_status.phy_status = `PHY_STATUS_W'(phy_sync[`SYNC_STAGES-1]);
      {o_status.mod_abs_chgd, o_status.tx_fault_chgd, o_status.rx_los_chgd} = chgd_q;
      o_status.mod_abs    = pins_cur.mod_abs;
      o_status.tx_fault   = pins_cur.tx_fault;
      o_status.rx_los     = pins_cur.rx_los;
   end

endmodule

`default_nettype wire

// ==== hw/status_readback.sv ====
//--------------------------------------------------------------------
// Status readback mux with free-running counter
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module status_readback (
   input  wire                           clk,
   input  wire                           i_reset,
   input  wire bus_int_pkg::reg_req_t    i_req,
   input  wire bus_int_pkg::board_ctrl_t i_board_ctrl,
   input  wire [7:0]                     i_clock_status,
   input  wire bus_int_pkg::sfp_status_t i_sfp0_status,
   input  wire bus_int_pkg::sfp_status_t i_sfp1_status,
   output logic [`BUS_INT_DATA_W-1:0]    o_rd_data,
   output logic                          o_rd_hit,
   output logic [1:0]                    o_status_clear
);

   logic [`BUS_INT_DATA_W-1:0] counter_q;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter_q <= '0;
      end else begin
         counter_q <= counter_q + 1'b1;
      end
   end

   //--------------------------------------------------------------------
   // Read word select
   //--------------------------------------------------------------------
   always_comb begin
      o_rd_hit = 1'b1;
      case (i_req.idx)
         `RB_COUNTER:      o_rd_data = counter_q;
         `RB_CLK_STATUS:   o_rd_data = `BUS_INT_DATA_W'(i_clock_status);
         `RB_COMPAT_NUM:   o_rd_data = {`COMPAT_MAJOR, `COMPAT_MINOR};
         `RB_SFPP_STATUS0: o_rd_data = i_sfp0_status;
         `RB_SFPP_STATUS1: o_rd_data = i_sfp1_status;
         `RB_FP_GPIO_SRC:  o_rd_data = `BUS_INT_DATA_W'(i_board_ctrl.fp_gpio_src);
         `RB_DEVICE_ID:    o_rd_data = `BUS_INT_DATA_W'(i_board_ctrl.device_id);
         default: begin
            o_rd_data = '0;
            o_rd_hit  = 1'b0;
         end
      endcase
   end

   // Reading a status word clears its change flags
   assign o_status_clear[0] = i_req.rd_stb && (i_req.idx == `RB_SFPP_STATUS0);
   assign o_status_clear[1] = i_req.rd_stb && (i_req.idx == `RB_SFPP_STATUS1);

endmodule

`default_nettype wire

// ==== hw/bus_int_top.sv ====
//--------------------------------------------------------------------
// Motherboard control block
// APB register access to board controls and status
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module bus_int_top (
   input  wire                         clk,
   input  wire                         i_reset,
   // APB slave
   input  wire                         i_psel,
   input  wire                         i_penable,
   input  wire                         i_pwrite,
   input  wire [`BUS_INT_REG_AW+1:0]   i_paddr,
   input  wire [`BUS_INT_DATA_W-1:0]   i_pwdata,
   output logic [`BUS_INT_DATA_W-1:0]  o_prdata,
   output logic                        o_pready,
   output logic                        o_pslverr,
   // Board status
   input  wire [7:0]                   i_clock_status,
   input  wire bus_int_pkg::sfp_pins_t i_sfp0_pins,
   input  wire bus_int_pkg::sfp_pins_t i_sfp1_pins,
   input  wire [`PHY_STATUS_W-1:0]     i_sfp0_phy_status,
   input  wire [`PHY_STATUS_W-1:0]     i_sfp1_phy_status,
   // Board controls
   output bus_int_pkg::board_ctrl_t    o_board_ctrl,
   output logic                        o_ref_freq_changed,
   output logic [3:0]                  o_sfpp_rs_drive
);

   import bus_int_pkg::*;

   reg_req_t                   req;
   logic [`BUS_INT_DATA_W-1:0] rd_data;
   logic                       rd_hit;
   logic [1:0]                 status_clear;
   sfp_status_t                sfp0_status;
   sfp_status_t                sfp1_status;

   //--------------------------------------------------------------------
   // Register access
   //--------------------------------------------------------------------
   apb_reg_bridge apb_bridge (
      .clk       (clk),
      .i_reset   (i_reset),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .i_rd_data (rd_data),
      .i_rd_hit  (rd_hit),
      .o_req     (req)
   );

   board_ctrl_regs ctrl_regs (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_req              (req),
      .o_board_ctrl       (o_board_ctrl),
      .o_ref_freq_changed (o_ref_freq_changed)
   );

   status_readback readback (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_req          (req),
      .i_board_ctrl   (o_board_ctrl),
      .i_clock_status (i_clock_status),
      .i_sfp0_status  (sfp0_status),
      .i_sfp1_status  (sfp1_status),
      .o_rd_data      (rd_data),
      .o_rd_hit       (rd_hit),
      .o_status_clear (status_clear)
   );

   //--------------------------------------------------------------------
   // SFP+ cages
   //--------------------------------------------------------------------
   sfp_status_monitor sfp0_monitor (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_pins       (i_sfp0_pins),
      .i_phy_status (i_sfp0_phy_status),
      .i_clear      (status_clear[0]),
      .o_status     (sfp0_status)
   );

   sfp_status_monitor sfp1_monitor (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_pins       (i_sfp1_pins),
      .i_phy_status (i_sfp1_phy_status),
      .i_clear      (status_clear[1]),
      .o_status     (sfp1_status)
   );

   // Rate select drive enables, pad buffers live in the chip top
   assign o_sfpp_rs_drive = {o_board_ctrl.sfpp1_rs, o_board_ctrl.sfpp0_rs};

endmodule

`default_nettype wire

// ==== testbench/bus_int_sva.sv ====
//--------------------------------------------------------------------
// Protocol and timing checks for the motherboard control block
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module bus_int_sva (
   input wire                       clk,
   input wire                       i_reset,
   input wire                       i_psel,
   input wire                       i_penable,
   input wire                       i_pwrite,
   input wire [`BUS_INT_REG_AW+1:0] i_paddr,
   input wire [`BUS_INT_DATA_W-1:0] i_pwdata,
   input wire [`BUS_INT_DATA_W-1:0] i_prdata,
   input wire                       i_pready,
   input wire                       i_pslverr,
   input wire                       i_ref_freq_changed,
   input wire [1:0]                 i_leds
);

   // Failed assertion count
   int fail_count = 0;

   // Zero wait states, ready only in the access phase
   assert property (@(posedge clk) disable iff (i_reset)
      i_pready == (i_psel && i_penable))
   else begin
      $error("pready does not match the APB access phase");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (i_reset)
      i_ref_freq_changed |=> !i_ref_freq_changed)
   else begin
      $error("ref_freq_changed held for more than one cycle");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (i_reset)
      i_pslverr |-> (i_prdata == '0))
   else begin
      $error("pslverr with nonzero read data");
      fail_count++;
   end

   //--------------------------------------------------------------------
   // LED write lands one cycle after the access
   //--------------------------------------------------------------------
   assert property (@(posedge clk) disable iff (i_reset)
      (i_psel && i_penable && i_pwrite && (i_paddr[`BUS_INT_REG_AW+1:2] == `SR_LEDS))
      |=> (i_leds == $past(i_pwdata[1:0])))
   else begin
      $error("LED field does not follow the written data");
      fail_count++;
   end

endmodule

bind bus_int_top bus_int_sva protocol_checks (
   .clk                (clk),
   .i_reset            (i_reset),
   .i_psel             (i_psel),
   .i_penable          (i_penable),
   .i_pwrite           (i_pwrite),
   .i_paddr            (i_paddr),
   .i_pwdata           (i_pwdata),
   .i_prdata           (o_prdata),
   .i_pready           (o_pready),
   .i_pslverr          (o_pslverr),
   .i_ref_freq_changed (o_ref_freq_changed),
   .i_leds             (o_board_ctrl.leds)
);

`default_nettype wire

// ==== testbench/bus_int_tb.sv ====
//--------------------------------------------------------------------
// Testbench for the motherboard control block
// Directed APB traffic with checks on controls and readback
//--------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "bus_int_macros.svh"

module bus_int_tb;

   import bus_int_pkg::*;

   localparam int READY_LIMIT = 8;
   localparam int POLL_LIMIT  = 20;
   localparam logic [7:0] WR_IDX [8] = '{`SR_LEDS, `SR_SW_RST, `SR_CLOCK_CTRL,
      `SR_DEVICE_ID, `SR_REF_FREQ, `SR_SFPP_CTRL0, `SR_SFPP_CTRL1, `SR_FP_GPIO_SRC};
   localparam int WR_WIDTH [8] = '{2, 4, 8, 16, 32, 2, 2, 24};

   string wr_name [8] = '{"leds", "sw_rst", "clock_control", "device_id",
                          "ref_freq", "sfpp0_rs", "sfpp1_rs", "fp_gpio_src"};

   logic                       clk;
   logic                       reset;
   logic                       psel;
   logic                       penable;
   logic                       pwrite;
   logic [`BUS_INT_REG_AW+1:0] paddr;
   logic [`BUS_INT_DATA_W-1:0] pwdata;
   logic [`BUS_INT_DATA_W-1:0] prdata;
   logic                       pready;
   logic                       pslverr;
   logic [7:0]                 clock_status;
   sfp_pins_t                  sfp0_pins;
   sfp_pins_t                  sfp1_pins;
   logic [`PHY_STATUS_W-1:0]   sfp0_phy;
   logic [`PHY_STATUS_W-1:0]   sfp1_phy;
   board_ctrl_t                board_ctrl;
   logic                       ref_freq_changed;
   logic [3:0]                 sfpp_rs_drive;
   int                         seed = 70;
   int                         pulse_count = 0;

   initial clk = 1'b0;
   always #2 clk = ~clk;

   bus_int_top bus_int_top_inst (
      .clk                (clk),
      .i_reset            (reset),
      .i_psel             (psel),
      .i_penable          (penable),
      .i_pwrite           (pwrite),
      .i_paddr            (paddr),
      .i_pwdata           (pwdata),
      .o_prdata           (prdata),
      .o_pready           (pready),
      .o_pslverr          (pslverr),
      .i_clock_status     (clock_status),
      .i_sfp0_pins        (sfp0_pins),
      .i_sfp1_pins        (sfp1_pins),
      .i_sfp0_phy_status  (sfp0_phy),
      .i_sfp1_phy_status  (sfp1_phy),
      .o_board_ctrl       (board_ctrl),
      .o_ref_freq_changed (ref_freq_changed),
      .o_sfpp_rs_drive    (sfpp_rs_drive)
   );

   // Count reference frequency pulses mid-cycle
   always @(negedge clk) begin
      if (!reset && ref_freq_changed) begin
         pulse_count <= pulse_count + 1;
      end
   end

   always @(negedge clk) begin
      if (bus_int_top_inst.protocol_checks.fail_count != 0) begin
         $display("Error: a concurrent protocol assertion failed");
         report_failure();
      end
   end

   task automatic report_failure();
      $display("Test failures found");
      $fatal(1, "Run stopped at the first failing check");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected)
      else begin
         $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
         report_failure();
      end
   endtask

   //--------------------------------------------------------------------
   // APB master
   //--------------------------------------------------------------------
   task automatic wait_ready();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (pready !== 1'b1 && cycles < READY_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (pready !== 1'b1) begin
         $display("Error: pready never came in the access phase");
         report_failure();
      end
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] idx, input logic [31:0] data,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= {idx, 2'b00};
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      wait_ready();
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] idx, input logic [31:0] data);
      logic [31:0] unused_data;
      logic        err;
      apb_access(1'b1, idx, data, unused_data, err);
      check_value("write_slverr", 32'd0, 32'(err));
   endtask

   task automatic apb_read(input logic [7:0] idx, output logic [31:0] data,
                           output logic err);
      apb_access(1'b0, idx, '0, data, err);
   endtask

   // Poll status 0 until the module-absent change flag shows up
   task automatic poll_mod_abs_chgd(output logic [31:0] word);
      int   reads;
      logic err;
      reads = 0;
      apb_read(`RB_SFPP_STATUS0, word, err);
      while (word[5] !== 1'b1 && reads < POLL_LIMIT) begin
         apb_read(`RB_SFPP_STATUS0, word, err);
         reads++;
      end
      if (word[5] !== 1'b1) begin
         $display("Error: mod_abs change flag of status 0 never set");
         report_failure();
      end
   endtask

   //--------------------------------------------------------------------
   // Reference models
   //--------------------------------------------------------------------
   function automatic logic [31:0] field_mask(input int width);
      return (width >= 32) ? 32'hFFFF_FFFF : ((32'd1 << width) - 32'd1);
   endfunction

   function automatic logic [31:0] ctrl_field(input board_ctrl_t ctrl, input logic [7:0] idx);
      case (idx)
         `SR_LEDS:        return 32'(ctrl.leds);
         `SR_SW_RST:      return 32'(ctrl.sw_rst);
         `SR_CLOCK_CTRL:  return 32'(ctrl.clock_control);
         `SR_DEVICE_ID:   return 32'(ctrl.device_id);
         `SR_REF_FREQ:    return ctrl.ref_freq;
         `SR_SFPP_CTRL0:  return 32'(ctrl.sfpp0_rs);
         `SR_SFPP_CTRL1:  return 32'(ctrl.sfpp1_rs);
         `SR_FP_GPIO_SRC: return 32'(ctrl.fp_gpio_src);
         default:         return '0;
      endcase
   endfunction

   function automatic logic [31:0] status_word(input logic [15:0] phy, input sfp_pins_t pins,
                                               input logic [2:0] chgd);
      return {phy, 10'b0, chgd, pins.mod_abs, pins.tx_fault, pins.rx_los};
   endfunction

   initial begin
      int          i;
      int          pulses_before;
      logic [31:0] wr_data [8];
      logic [31:0] word;
      logic [31:0] count_a;
      logic        err;
      logic [7:0]  clk_stat;
      sfp_pins_t   pins_new;
      board_ctrl_t exp_ctrl;

      reset        = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      clock_status = '0;
      sfp0_pins    = 3'($random(seed));
      sfp1_pins    = 3'($random(seed));
      sfp0_phy     = 16'($random(seed));
      sfp1_phy     = 16'($random(seed));
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      // Reset values
      @(negedge clk);
      check_value("reset_clock_control", 32'h40, 32'(board_ctrl.clock_control));
      check_value("reset_ref_freq", 32'd10_000_000, board_ctrl.ref_freq);
      check_value("reset_leds", 32'd0, 32'(board_ctrl.leds));
      check_value("reset_sw_rst", 32'd0, 32'(board_ctrl.sw_rst));
      check_value("reset_rs_drive", 32'd0, 32'(sfpp_rs_drive));
      check_value("reset_fp_gpio_src", 32'd0, 32'(board_ctrl.fp_gpio_src));
      check_value("reset_apb_outputs", 32'd0, {pready, pslverr, ref_freq_changed} | prdata);

      // Each write lands truncated, only ref_freq pulses
      for (i = 0; i < 8; i++) begin
         wr_data[i]    = $random(seed);
         pulses_before = pulse_count;
         apb_write(WR_IDX[i], wr_data[i]);
         @(negedge clk);
         check_value(wr_name[i], wr_data[i] & field_mask(WR_WIDTH[i]),
                     ctrl_field(board_ctrl, WR_IDX[i]));
         @(negedge clk);
         check_value({wr_name[i], "_pulses"}, (WR_IDX[i] == `SR_REF_FREQ) ? 32'd1 : 32'd0,
                     32'(pulse_count - pulses_before));
      end
      check_value("rs_drive", {28'd0, wr_data[6][1:0], wr_data[5][1:0]}, 32'(sfpp_rs_drive));

      // Readback map
      apb_read(`RB_COMPAT_NUM, word, err);
      check_value("compat", 32'h0027_0000, word);
      apb_read(`RB_DEVICE_ID, word, err);
      check_value("device_id_readback", {16'd0, wr_data[3][15:0]}, word);
      apb_read(`RB_FP_GPIO_SRC, word, err);
      check_value("fp_gpio_readback", {8'd0, wr_data[7][23:0]}, word);
      clk_stat = 8'($random(seed));
      @(posedge clk);
      clock_status <= clk_stat;
      apb_read(`RB_CLK_STATUS, word, err);
      check_value("clock_status", {24'd0, clk_stat}, word);
      apb_read(`RB_COUNTER, count_a, err);
      repeat (3) apb_read(`RB_COMPAT_NUM, word, err);
      apb_read(`RB_COUNTER, word, err);
      assert (word > count_a)
      else begin
         $display("Error: counter expected above 0x%08h actual 0x%08h", count_a, word);
         report_failure();
      end

      // Sticky flags of cage 0, cage 1 left alone
      apb_read(`RB_SFPP_STATUS1, word, err);
      check_value("status1_before", status_word(sfp1_phy, sfp1_pins, 3'b000), word);
      apb_read(`RB_SFPP_STATUS0, word, err);
      check_value("status0_idle", status_word(sfp0_phy, sfp0_pins, 3'b000), word);
      pins_new         = sfp0_pins;
      pins_new.mod_abs = ~pins_new.mod_abs;
      @(posedge clk);
      sfp0_pins <= pins_new;
      sfp0_phy  <= ~sfp0_phy;
      poll_mod_abs_chgd(word);
      check_value("status0_changed", status_word(sfp0_phy, pins_new, 3'b100), word);
      apb_read(`RB_SFPP_STATUS0, word, err);
      check_value("status0_cleared", status_word(sfp0_phy, pins_new, 3'b000), word);
      apb_read(`RB_SFPP_STATUS1, word, err);
      check_value("status1_after", status_word(sfp1_phy, sfp1_pins, 3'b000), word);

      // Unmapped accesses
      apb_read(8'd100, word, err);
      check_value("unmapped_read_data", 32'd0, word);
      check_value("unmapped_read_slverr", 32'd1, 32'(err));
      // Controls still hold the last mapped writes
      exp_ctrl.leds          = wr_data[0][1:0];
      exp_ctrl.sw_rst        = wr_data[1][3:0];
      exp_ctrl.clock_control = wr_data[2][7:0];
      exp_ctrl.device_id     = wr_data[3][15:0];
      exp_ctrl.ref_freq      = wr_data[4];
      exp_ctrl.sfpp0_rs      = wr_data[5][1:0];
      exp_ctrl.sfpp1_rs      = wr_data[6][1:0];
      exp_ctrl.fp_gpio_src   = wr_data[7][23:0];
      apb_write(8'd50, $random(seed));
      @(negedge clk);
      assert (board_ctrl === exp_ctrl)
      else begin
         $display("Error: unmapped_write expected %h actual %h", exp_ctrl, board_ctrl);
         report_failure();
      end

      @(negedge clk);
      if (bus_int_top_inst.protocol_checks.fail_count != 0) begin
         $display("Error: a concurrent protocol assertion failed");
         report_failure();
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/bus_int_pkg.sv
hw/apb_reg_bridge.sv
hw/board_ctrl_regs.sv
hw/sfp_status_monitor.sv
hw/status_readback.sv
hw/bus_int_top.sv
testbench/bus_int_sva.sv
testbench/bus_int_tb.sv

// ==== Bender.yml ====
package:
  name: bus_int

sources:
  - include_dirs:
      - hw
    files:
      - hw/bus_int_pkg.sv
      - hw/apb_reg_bridge.sv
      - hw/board_ctrl_regs.sv
      - hw/sfp_status_monitor.sv
      - hw/status_readback.sv
      - hw/bus_int_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/bus_int_sva.sv
      - testbench/bus_int_tb.sv
